//--- hdl/uart_apb_bridge.sv
`default_nettype none

module uart_apb_bridge #(
   parameter int BIG_ENDIAN = 0   // 1: lane 0 sits on pwdata[31:24]
) (
   input  wire                  clock,
   input  wire                  rst_n_i,
   input  wire                  psel_i,
   input  wire                  penable_i,
   input  wire                  pwrite_i,
   input  wire  [31:0]          paddr_i,
   input  wire  [31:0]          pwdata_i,
   output logic [31:0]          prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   output logic                 reg_we_o,
   output logic                 reg_re_o,
   output logic [2:0]           reg_adr_o,
   output uart_pkg::byte_t      reg_wdat_o,
   input  wire uart_pkg::byte_t reg_rdat_i
);

   logic [1:0]      lane;        // byte lane after endian swap
   uart_pkg::byte_t lane_byte;   // byte picked from pwdata

   // -------------------------------------------------------------------------
   // setup phase strobes
   // -------------------------------------------------------------------------
   assign reg_we_o  = rst_n_i & psel_i & ~penable_i & pwrite_i;
   assign reg_re_o  = rst_n_i & psel_i & ~penable_i & ~pwrite_i;   // regs latch data here
   assign reg_adr_o = paddr_i[2:0];

   assign pready_o  = psel_i & penable_i;   // zero wait states
   assign pslverr_o = 1'b0;

   // -------------------------------------------------------------------------
   // write lane select
   // -------------------------------------------------------------------------
   assign lane = (BIG_ENDIAN != 0) ? 2'd3 - paddr_i[1:0] : paddr_i[1:0];

   always_comb begin
      case (lane)
         2'd0:    lane_byte = pwdata_i[7:0];
         2'd1:    lane_byte = pwdata_i[15:8];
         2'd2:    lane_byte = pwdata_i[23:16];
         default: lane_byte = pwdata_i[31:24];
      endcase
   end

   // byte taken on the setup strobe
   assign reg_wdat_o = lane_byte;

   // read byte on all four lanes, bus quiet when not selected
   assign prdata_o = psel_i ? {4{reg_rdat_i}} : 32'h0;

endmodule

`default_nettype wire

//--- hdl/uart_fifo.sv
`default_nettype none

module uart_fifo #(
   parameter int  FIFO_DEPTH = uart_pkg::FIFO_DEPTH_DEFAULT,
   parameter type payload_t  = uart_pkg::byte_t
) (
   input  wire           clock,
   input  wire           rst_n_i,
   input  wire           push_i,
   input  wire payload_t wdata_i,
   input  wire           pop_i,
   output payload_t      rdata_o,
   output logic          full_o,
   output logic          empty_o
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   payload_t      mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr, rd_ptr;
   logic [CW-1:0] count;
   logic          do_push, do_pop;

   // wrap at depth, any depth works
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + AW'(1);
   endfunction

   assign full_o  = (count == CW'(FIFO_DEPTH));
   assign empty_o = (count == '0);
   assign do_push = push_i & ~full_o;   // push into full fifo ignored
   assign do_pop  = pop_i & ~empty_o;
   assign rdata_o = mem[rd_ptr];        // head, no latency

   always_ff @(posedge clock) begin
      if (do_push) mem[wr_ptr] <= wdata_i;
   end

   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + CW'(1);
            2'b01:   count <= count - CW'(1);
            default: ;   // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

   // -------------------------------------------------------------------------
   // register offsets on paddr[2:0]
   // -------------------------------------------------------------------------
   localparam logic [2:0] ADDR_RBR_THR = 3'd0;   // dll while dlab set
   localparam logic [2:0] ADDR_IER     = 3'd1;   // dlm while dlab set
   localparam logic [2:0] ADDR_LCR     = 3'd3;
   localparam logic [2:0] ADDR_MCR     = 3'd4;
   localparam logic [2:0] ADDR_LSR     = 3'd5;   // read only

   // line status bits
   localparam int LSR_DR   = 0;   // rx data ready
   localparam int LSR_OE   = 1;   // overrun, sticky
   localparam int LSR_FE   = 3;   // framing error
   localparam int LSR_THRE = 5;   // tx fifo empty
   localparam int LSR_TEMT = 6;   // tx fifo and shifter empty

   // control bits
   localparam int LCR_DLAB = 7;
   localparam int MCR_LOOP = 4;
   localparam int IER_RDA  = 0;
   localparam int IER_THRE = 1;

   // -------------------------------------------------------------------------
   // payloads
   // -------------------------------------------------------------------------
   typedef logic [7:0] byte_t;

   // rx fifo entry, 9 bits
   typedef struct packed {
      logic  frame_err;   // stop bit sampled low
      byte_t data;
   } rx_entry_t;

   localparam int FIFO_DEPTH_DEFAULT = 16;

endpackage

`default_nettype wire

//--- hdl/uart_regs.sv
`default_nettype none

module uart_regs #(
   parameter int FIFO_DEPTH = uart_pkg::FIFO_DEPTH_DEFAULT
) (
   input  wire                      clock,
   input  wire                      rst_n_i,
   input  wire                      reg_we_i,
   input  wire                      reg_re_i,
   input  wire [2:0]                reg_adr_i,
   input  wire uart_pkg::byte_t     reg_wdat_i,
   output uart_pkg::byte_t          reg_rdat_o,
   output logic                     tx_push_o,
   output uart_pkg::byte_t          tx_wdat_o,
   input  wire                      tx_full_i,
   input  wire                      tx_empty_i,
   input  wire                      tx_busy_i,
   output logic                     rx_pop_o,
   input  wire uart_pkg::rx_entry_t rx_head_i,
   input  wire                      rx_empty_i,
   input  wire                      rx_full_i,
   input  wire                      rx_valid_i,
   output logic                     baud_tick_o,
   output logic                     loop_o,
   output logic                     irq_o
);

   localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

   uart_pkg::byte_t  ier_q, lcr_q, mcr_q, dll_q, dlm_q;
   uart_pkg::byte_t  last_rbr_q;   // last byte taken from the rx fifo
   uart_pkg::byte_t  lsr, rd_mux;
   logic [15:0]      divisor, div_cnt;
   logic [LVL_W-1:0] rx_level;     // entries waiting in rx fifo
   logic             oe_q, fe_q;
   logic             dlab, sel_data, lsr_rd, rx_in, rx_out, rx_drop;

   assign dlab     = lcr_q[uart_pkg::LCR_DLAB];
   assign sel_data = (reg_adr_i == uart_pkg::ADDR_RBR_THR) & ~dlab;
   assign lsr_rd   = reg_re_i & (reg_adr_i == uart_pkg::ADDR_LSR);
   assign divisor  = {dlm_q, dll_q};

   // fifo strobes
   assign tx_push_o = reg_we_i & sel_data & ~tx_full_i;   // full: byte lost
   assign tx_wdat_o = reg_wdat_i;
   assign rx_pop_o  = reg_re_i & sel_data;

   // -------------------------------------------------------------------------
   // control registers and divisor latch
   // -------------------------------------------------------------------------
   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ier_q <= '0;
         lcr_q <= '0;
         mcr_q <= '0;
         dll_q <= '0;
         dlm_q <= '0;
      end else if (reg_we_i) begin
         case (reg_adr_i)
            uart_pkg::ADDR_RBR_THR: if (dlab) dll_q <= reg_wdat_i;
            uart_pkg::ADDR_IER: begin
               if (dlab) dlm_q <= reg_wdat_i;
               else      ier_q <= reg_wdat_i;
            end
            uart_pkg::ADDR_LCR: lcr_q <= reg_wdat_i;
            uart_pkg::ADDR_MCR: mcr_q <= reg_wdat_i;
            default: ;   // lsr and holes ignore writes
         endcase
      end
   end

   // 16x baud divider, one tick every divisor cycles
   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         div_cnt     <= '0;
         baud_tick_o <= 1'b0;
      end else if (divisor == 16'd0) begin
         div_cnt     <= '0;   // stopped
         baud_tick_o <= 1'b0;
      end else if (div_cnt >= divisor - 16'd1) begin
         div_cnt     <= '0;
         baud_tick_o <= 1'b1;
      end else begin
         div_cnt     <= div_cnt + 16'd1;
         baud_tick_o <= 1'b0;
      end
   end

   // -------------------------------------------------------------------------
   // rx occupancy, sticky status
   // -------------------------------------------------------------------------
   assign rx_in   = rx_valid_i & ~rx_full_i;
   assign rx_out  = rx_pop_o & ~rx_empty_i;
   assign rx_drop = rx_valid_i & (rx_level == LVL_W'(FIFO_DEPTH));   // overrun

   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rx_level   <= '0;
         oe_q       <= 1'b0;
         fe_q       <= 1'b0;
         last_rbr_q <= '0;
      end else begin
         if (rx_in & ~rx_out)      rx_level <= rx_level + LVL_W'(1);
         else if (rx_out & ~rx_in) rx_level <= rx_level - LVL_W'(1);
         if (rx_drop)     oe_q <= 1'b1;   // set wins over the clear
         else if (lsr_rd) oe_q <= 1'b0;
         if (lsr_rd)                                  fe_q <= 1'b0;
         else if (~rx_empty_i & rx_head_i.frame_err) fe_q <= 1'b1;
         if (rx_out) last_rbr_q <= rx_head_i.data;
      end
   end

   always_comb begin
      lsr                     = '0;
      lsr[uart_pkg::LSR_DR]   = ~rx_empty_i;
      lsr[uart_pkg::LSR_OE]   = oe_q;
      lsr[uart_pkg::LSR_FE]   = fe_q | (~rx_empty_i & rx_head_i.frame_err);
      lsr[uart_pkg::LSR_THRE] = tx_empty_i;
      lsr[uart_pkg::LSR_TEMT] = tx_empty_i & ~tx_busy_i;   // shifter idle too
   end

   // -------------------------------------------------------------------------
   // read path, registered on the setup strobe
   // -------------------------------------------------------------------------
   always_comb begin
      case (reg_adr_i)
         uart_pkg::ADDR_RBR_THR: begin
            if (dlab)            rd_mux = dll_q;
            else if (rx_empty_i) rd_mux = last_rbr_q;   // repeat last byte
            else                 rd_mux = rx_head_i.data;
         end
         uart_pkg::ADDR_IER: rd_mux = dlab ? dlm_q : ier_q;
         uart_pkg::ADDR_LCR: rd_mux = lcr_q;
         uart_pkg::ADDR_MCR: rd_mux = mcr_q;
         uart_pkg::ADDR_LSR: rd_mux = lsr;
         default:            rd_mux = '0;
      endcase
   end

   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_rdat_o <= '0;
      end else if (reg_re_i) begin
         reg_rdat_o <= rd_mux;
      end
   end

   assign loop_o = mcr_q[uart_pkg::MCR_LOOP];
   assign irq_o  = (ier_q[uart_pkg::IER_RDA] & ~rx_empty_i)
                 | (ier_q[uart_pkg::IER_THRE] & tx_empty_i);

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`default_nettype none

module uart_rx (
   input  wire                 clock,
   input  wire                 rst_n_i,
   input  wire                 baud_tick_i,
   input  wire                 rx_i,
   input  wire                 loop_i,
   input  wire                 tx_loop_i,   // transmitter line
   output logic                rx_valid_o,
   output uart_pkg::rx_entry_t rx_entry_o
);

   typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

   state_t          state;
   logic            sync1, sync2, prev;   // 2-flop sync, edge history
   logic [3:0]      tick_cnt;
   logic [2:0]      bit_cnt;
   uart_pkg::byte_t data_q;
   logic            rx_sel, mid_bit;

   assign rx_sel  = loop_i ? tx_loop_i : rx_i;
   assign mid_bit = baud_tick_i & (tick_cnt == 4'd15);   // 16 ticks on

   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync1 <= 1'b1;   // idle line level
         sync2 <= 1'b1;
         prev  <= 1'b1;
      end else begin
         sync1 <= rx_sel;
         sync2 <= sync1;
         prev  <= sync2;
      end
   end

   // -------------------------------------------------------------------------
   // frame FSM
   // -------------------------------------------------------------------------
   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state      <= S_IDLE;
         tick_cnt   <= '0;
         bit_cnt    <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         rx_valid_o <= 1'b0;
         case (state)
            S_IDLE: begin
               tick_cnt <= '0;
               if (prev & ~sync2) state <= S_START;   // falling edge
            end
            S_START: begin
               if (baud_tick_i) begin
                  tick_cnt <= tick_cnt + 4'd1;
                  if (tick_cnt == 4'd7) begin   // middle of start bit
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     state    <= sync2 ? S_IDLE : S_DATA;   // glitch dropped
                  end
               end
            end
            S_DATA: begin
               if (baud_tick_i) tick_cnt <= tick_cnt + 4'd1;
               if (mid_bit) begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) state <= S_STOP;
               end
            end
            default: begin   // stop bit
               if (baud_tick_i) tick_cnt <= tick_cnt + 4'd1;
               if (mid_bit) begin
                  rx_valid_o <= 1'b1;
                  state      <= S_IDLE;
               end
            end
         endcase
      end
   end

   // data path, lsb first
   always_ff @(posedge clock) begin
      if (state == S_DATA && mid_bit) data_q <= {sync2, data_q[7:1]};
      if (state == S_STOP && mid_bit) begin
         rx_entry_o.data      <= data_q;
         rx_entry_o.frame_err <= ~sync2;   // stop bit must be 1
      end
   end

endmodule

`default_nettype wire

//--- hdl/uart_top_apb.sv
`default_nettype none

module uart_top_apb #(
   parameter int FIFO_DEPTH = uart_pkg::FIFO_DEPTH_DEFAULT,
   parameter int BIG_ENDIAN = 0
) (
   input  wire         clock,
   input  wire         rst_n_i,
   input  wire         psel_i,
   input  wire         penable_i,
   input  wire         pwrite_i,
   input  wire  [31:0] paddr_i,
   input  wire  [31:0] pwdata_i,
   input  wire  [3:0]  pstrb_i,   // accepted, byte lane comes from paddr
   output logic [31:0] prdata_o,
   output logic        pready_o,
   output logic        pslverr_o,
   input  wire         uart_rx_i,
   output logic        uart_tx_o,
   output logic        irq_o
);

   // bridge to regs
   logic                reg_we, reg_re;
   logic [2:0]          reg_adr;
   uart_pkg::byte_t     reg_wdat, reg_rdat;
   // tx side
   logic                tx_push, tx_pop, tx_full, tx_empty, tx_busy, tx_line;
   uart_pkg::byte_t     tx_wdat, tx_head;
   // rx side
   logic                rx_pop, rx_valid, rx_full, rx_empty;
   uart_pkg::rx_entry_t rx_entry, rx_head;
   logic                baud_tick, loop;

   uart_apb_bridge #(.BIG_ENDIAN(BIG_ENDIAN)) u_bridge (
      .clock(clock), .rst_n_i(rst_n_i),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
      .pready_o(pready_o), .pslverr_o(pslverr_o),
      .reg_we_o(reg_we), .reg_re_o(reg_re), .reg_adr_o(reg_adr),
      .reg_wdat_o(reg_wdat), .reg_rdat_i(reg_rdat)
   );

   uart_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
      .clock(clock), .rst_n_i(rst_n_i),
      .reg_we_i(reg_we), .reg_re_i(reg_re), .reg_adr_i(reg_adr),
      .reg_wdat_i(reg_wdat), .reg_rdat_o(reg_rdat),
      .tx_push_o(tx_push), .tx_wdat_o(tx_wdat), .tx_full_i(tx_full),
      .tx_empty_i(tx_empty), .tx_busy_i(tx_busy),
      .rx_pop_o(rx_pop), .rx_head_i(rx_head), .rx_empty_i(rx_empty),
      .rx_full_i(rx_full), .rx_valid_i(rx_valid),
      .baud_tick_o(baud_tick), .loop_o(loop), .irq_o(irq_o)
   );

   uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(uart_pkg::byte_t)) u_tx_fifo (
      .clock(clock), .rst_n_i(rst_n_i),
      .push_i(tx_push), .wdata_i(tx_wdat), .pop_i(tx_pop),
      .rdata_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
   );

   // rx fifo pushed straight by the receiver, drops when full
   uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(uart_pkg::rx_entry_t)) u_rx_fifo (
      .clock(clock), .rst_n_i(rst_n_i),
      .push_i(rx_valid), .wdata_i(rx_entry), .pop_i(rx_pop),
      .rdata_o(rx_head), .full_o(rx_full), .empty_o(rx_empty)
   );

   uart_tx u_tx (
      .clock(clock), .rst_n_i(rst_n_i), .baud_tick_i(baud_tick),
      .fifo_empty_i(tx_empty), .fifo_data_i(tx_head), .loop_i(loop),
      .fifo_pop_o(tx_pop), .tx_o(uart_tx_o), .line_o(tx_line), .busy_o(tx_busy)
   );

   uart_rx u_rx (
      .clock(clock), .rst_n_i(rst_n_i), .baud_tick_i(baud_tick),
      .rx_i(uart_rx_i), .loop_i(loop), .tx_loop_i(tx_line),
      .rx_valid_o(rx_valid), .rx_entry_o(rx_entry)
   );

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none

module uart_tx (
   input  wire                  clock,
   input  wire                  rst_n_i,
   input  wire                  baud_tick_i,
   input  wire                  fifo_empty_i,
   input  wire uart_pkg::byte_t fifo_data_i,
   input  wire                  loop_i,
   output logic                 fifo_pop_o,
   output logic                 tx_o,
   output logic                 line_o,   // raw line for loopback
   output logic                 busy_o
);

   logic [9:0] shift_q;    // stop, data lsb first, start
   logic [3:0] tick_cnt;   // 16 ticks per bit
   logic [3:0] bit_cnt;    // 0 start .. 9 stop
   logic       bit_end;

   assign bit_end    = busy_o & baud_tick_i & (tick_cnt == 4'd15);
   assign fifo_pop_o = ~busy_o & ~fifo_empty_i;   // one cycle, busy follows
   assign line_o     = busy_o ? shift_q[0] : 1'b1;
   assign tx_o       = line_o | loop_i;           // pin parked in loopback

   always_ff @(posedge clock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_o   <= 1'b0;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else if (fifo_pop_o) begin
         busy_o   <= 1'b1;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else if (busy_o & baud_tick_i) begin
         tick_cnt <= tick_cnt + 4'd1;
         if (bit_end) begin
            if (bit_cnt == 4'd9) busy_o <= 1'b0;   // stop bit done
            else                 bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   // frame shifter
   always_ff @(posedge clock) begin
      if (fifo_pop_o) shift_q <= {1'b1, fifo_data_i, 1'b0};
      else if (bit_end) shift_q <= {1'b1, shift_q[9:1]};
   end

endmodule

`default_nettype wire

//--- list.f
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_apb_bridge.sv
hdl/uart_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top_apb.sv
testbench/uart_asserts.sv
testbench/tb_uart.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the uart testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_uart \
   -f list.f \
   --Mdir obj_dir

# keep running past an assertion $error so the testbench can report it
./obj_dir/Vtb_uart +verilator+error+limit+100

//--- testbench/tb_uart.sv
`default_nettype none

module tb_uart;

   localparam int FIFO_DEPTH     = 16;
   localparam int DIVISOR        = 2;
   localparam int BIT_CYCLES     = 16 * DIVISOR;   // 32 cycles per bit
   localparam int TIMEOUT_CYCLES = 40000;          // ~28 frames of 320, wide margin

   logic        clock = 1'b0;
   logic        rst_n;
   logic        psel, penable, pwrite;
   logic [31:0] paddr, pwdata, prdata;
   logic [3:0]  pstrb;
   logic        pready, pslverr;
   logic        uart_rx, uart_tx, irq;
   int          cycle_cnt = 0;

   uart_top_apb #(.FIFO_DEPTH(FIFO_DEPTH), .BIG_ENDIAN(0)) u_dut (
      .clock(clock), .rst_n_i(rst_n),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
      .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
      .uart_rx_i(uart_rx), .uart_tx_o(uart_tx), .irq_o(irq)
   );

   always #50 clock = ~clock;

   // -------------------------------------------------------------------------
   // helpers
   // -------------------------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else abort_run($sformatf("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
   endtask

   // byte goes on the lane picked by adr[1:0], other lanes carry noise
   task automatic apb_write(input logic [2:0] adr, input logic [7:0] data);
      logic [31:0] word;
      word = $urandom;
      word[8*adr[1:0] +: 8] = data;
      @(negedge clock);
      psel    = 1'b1;   // setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = {29'h0, adr};
      pwdata  = word;
      @(negedge clock);
      penable = 1'b1;
      @(negedge clock);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [2:0] adr, output logic [31:0] word);
      @(negedge clock);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = {29'h0, adr};
      @(negedge clock);
      penable = 1'b1;
      @(negedge clock);
      word    = prdata;   // end of access phase
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // every lane must carry the same byte
   task automatic check_read(input logic [2:0] adr, input logic [7:0] exp,
                             input logic [7:0] mask, input string name);
      logic [31:0] word;
      apb_read(adr, word);
      check_value(name, word & {4{mask}}, {4{exp & mask}});
   endtask

   task automatic wait_lsr(input int idx, input logic val);
      logic [31:0] word;
      apb_read(uart_pkg::ADDR_LSR, word);
      while (word[idx] !== val) apb_read(uart_pkg::ADDR_LSR, word);
   endtask

   // serial model, start bit, data lsb first, chosen stop level
   task automatic drive_frame(input logic [7:0] data, input logic stop);
      logic [9:0] frame;
      frame = {stop, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         uart_rx = frame[i];
         repeat (BIT_CYCLES) @(negedge clock);
      end
      uart_rx = 1'b1;
   endtask

   task automatic expect_tx_frame(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      while (uart_tx !== 1'b0) @(negedge clock);   // start edge
      repeat (BIT_CYCLES / 2) @(negedge clock);     // to bit centre
      for (int i = 0; i < 10; i++) begin
         check_value($sformatf("uart_tx_o bit %0d", i), {31'h0, uart_tx}, {31'h0, frame[i]});
         if (i < 9) repeat (BIT_CYCLES) @(negedge clock);
      end
   endtask

   // watchdog and bound assertion monitor
   always @(negedge clock) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         abort_run("timeout, the DUT stopped making progress");
      else if (u_dut.u_asserts.fail_cnt != 0)
         abort_run("a concurrent assertion in uart_asserts failed");
   end

   // -------------------------------------------------------------------------
   // tests
   // -------------------------------------------------------------------------
   initial begin
      logic [7:0] b;
      logic [7:0] sent [$];   // bytes in flight, oldest first
      void'($urandom(32'h232407c3));
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      pstrb   = 4'hf;
      uart_rx = 1'b1;   // idle line
      repeat (3) @(posedge clock);
      @(negedge clock);
      rst_n = 1'b1;

      // reset state
      check_value("uart_tx_o", {31'h0, uart_tx}, 32'h1);
      check_value("irq_o", {31'h0, irq}, 32'h0);
      check_read(uart_pkg::ADDR_LSR, 8'h60, 8'hff, "prdata_o (lsr after reset)");

      // register access, divisor through dlab
      apb_write(uart_pkg::ADDR_LCR, 8'h80);
      check_read(uart_pkg::ADDR_LCR, 8'h80, 8'hff, "prdata_o (lcr)");
      apb_write(uart_pkg::ADDR_RBR_THR, 8'(DIVISOR));
      apb_write(uart_pkg::ADDR_IER, 8'ha5);   // dlm, slow divisor for a moment
      check_read(uart_pkg::ADDR_RBR_THR, 8'(DIVISOR), 8'hff, "prdata_o (dll)");
      check_read(uart_pkg::ADDR_IER, 8'ha5, 8'hff, "prdata_o (dlm)");
      apb_write(uart_pkg::ADDR_IER, 8'h00);
      check_read(uart_pkg::ADDR_IER, 8'h00, 8'hff, "prdata_o (dlm)");
      apb_write(uart_pkg::ADDR_LCR, 8'h1b);
      check_read(uart_pkg::ADDR_LCR, 8'h1b, 8'hff, "prdata_o (lcr)");
      apb_write(uart_pkg::ADDR_IER, 8'hf0);   // no irq source bits
      check_read(uart_pkg::ADDR_IER, 8'hf0, 8'hff, "prdata_o (ier)");
      apb_write(uart_pkg::ADDR_IER, 8'h00);
      apb_write(uart_pkg::ADDR_MCR, 8'h0c);
      check_read(uart_pkg::ADDR_MCR, 8'h0c, 8'hff, "prdata_o (mcr)");
      apb_write(uart_pkg::ADDR_MCR, 8'h00);

      // serial transmit on the pin
      b = 8'($urandom);
      apb_write(uart_pkg::ADDR_RBR_THR, b);
      expect_tx_frame(b);
      wait_lsr(uart_pkg::LSR_TEMT, 1'b1);
      check_read(uart_pkg::ADDR_LSR, 8'h60, 8'hff, "prdata_o (lsr after transmit)");

      // loopback receive, order kept
      apb_write(uart_pkg::ADDR_MCR, 8'h10);
      for (int i = 0; i < 8; i++) begin
         b = 8'($urandom);
         sent.push_back(b);
         apb_write(uart_pkg::ADDR_RBR_THR, b);
      end
      for (int i = 0; i < 8; i++) begin
         wait_lsr(uart_pkg::LSR_DR, 1'b1);
         check_read(uart_pkg::ADDR_RBR_THR, sent.pop_front(), 8'hff, "prdata_o (rbr)");
      end
      check_read(uart_pkg::ADDR_LSR, 8'h00, 8'h01 << uart_pkg::LSR_DR, "prdata_o (lsr dr)");

      // overrun, one frame more than the rx fifo holds
      for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
         b = 8'($urandom);
         sent.push_back(b);
         apb_write(uart_pkg::ADDR_RBR_THR, b);
      end
      wait_lsr(uart_pkg::LSR_OE, 1'b1);
      for (int i = 0; i < FIFO_DEPTH; i++)
         check_read(uart_pkg::ADDR_RBR_THR, sent.pop_front(), 8'hff, "prdata_o (rbr)");
      sent.delete();   // last byte was dropped
      check_read(uart_pkg::ADDR_LSR, 8'h00, 8'h01 << uart_pkg::LSR_DR, "prdata_o (lsr dr)");
      wait_lsr(uart_pkg::LSR_TEMT, 1'b1);
      apb_write(uart_pkg::ADDR_MCR, 8'h00);

      // framing error from the pin
      b = 8'($urandom);
      drive_frame(b, 1'b0);
      wait_lsr(uart_pkg::LSR_DR, 1'b1);
      check_read(uart_pkg::ADDR_LSR, 8'h69, 8'hff, "prdata_o (lsr framing)");
      check_read(uart_pkg::ADDR_RBR_THR, b, 8'hff, "prdata_o (rbr framing)");

      // interrupt levels
      apb_write(uart_pkg::ADDR_IER, 8'h01);
      check_value("irq_o", {31'h0, irq}, 32'h0);
      b = 8'($urandom);
      drive_frame(b, 1'b1);
      while (irq !== 1'b1) @(negedge clock);
      check_read(uart_pkg::ADDR_RBR_THR, b, 8'hff, "prdata_o (rbr irq)");
      check_value("irq_o", {31'h0, irq}, 32'h0);
      apb_write(uart_pkg::ADDR_IER, 8'h02);   // tx fifo is empty
      check_value("irq_o", {31'h0, irq}, 32'h1);
      apb_write(uart_pkg::ADDR_IER, 8'h00);

      if (u_dut.u_asserts.fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         abort_run("concurrent assertion failures were counted");
      end
   end

endmodule

`default_nettype wire

//--- testbench/uart_asserts.sv
`default_nettype none

module uart_asserts (
   input wire                  clock,
   input wire                  rst_n_i,
   input wire                  psel_i,
   input wire                  penable_i,
   input wire                  pready_i,
   input wire                  pslverr_i,
   input wire                  uart_tx_i,
   input wire                  irq_i,
   input wire                  loop_i,   // mcr loopback bit
   input wire uart_pkg::byte_t ier_i
);

   int unsigned fail_cnt = 0;   // watched by the testbench

   // -------------------------------------------------------------------------
   // apb side
   // -------------------------------------------------------------------------
   pready_follows: assert property (@(posedge clock) disable iff (!rst_n_i)
         pready_i == (psel_i & penable_i))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("pready_o differs from psel_i and penable_i");
      end

   no_slverr: assert property (@(posedge clock) disable iff (!rst_n_i)
         pslverr_i == 1'b0)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("pslverr_o went high");
      end

   // pin parked high while the receiver listens to the transmitter
   tx_idle_in_loop: assert property (@(posedge clock) disable iff (!rst_n_i)
         loop_i |-> uart_tx_i)
      else begin
         fail_cnt = fail_cnt + 1;
         $error("uart_tx_o low while loopback is set");
      end

   irq_quiet: assert property (@(posedge clock) disable iff (!rst_n_i)
         (ier_i == '0) |-> !irq_i)   // no source enabled
      else begin
         fail_cnt = fail_cnt + 1;
         $error("irq_o high while ier is zero");
      end

endmodule

bind uart_top_apb uart_asserts u_asserts (
   .clock(clock), .rst_n_i(rst_n_i),
   .psel_i(psel_i), .penable_i(penable_i),
   .pready_i(pready_o), .pslverr_i(pslverr_o),
   .uart_tx_i(uart_tx_o), .irq_i(irq_o),
   .loop_i(loop), .ier_i(u_regs.ier_q)
);

`default_nettype wire
